/* common/csi2_data_types_pkg.sv */
package csi2_data_types_pkg;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data type codes
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [5:0] RAW_10      = 6'h2B;
  localparam logic [5:0] FRAME_START = 6'h00;  // Short packets
  localparam logic [5:0] FRAME_END   = 6'h01;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pixel format
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int PX_W       = 10;
  localparam int PX_PER_GRP = 4;   // RAW10 packs 4 pixels into 5 bytes

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Packet header word with byte 0 in bits 7:0
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] word_cnt;   // Payload length in bytes
    logic [1:0]  vc;
    logic [5:0]  data_type;
  } csi2_long_hdr_t;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] data_field; // Frame number for FS/FE
    logic [1:0]  vc;
    logic [5:0]  data_type;
  } csi2_short_hdr_t;

  // Same word read either as long or short header
  typedef union packed {
    csi2_long_hdr_t  lng;
    csi2_short_hdr_t shrt;
  } csi2_hdr_t;

endpackage

/* common/axi4_stream_if.sv */
`timescale 1ns/10ps

interface axi4_stream_if;

  logic [31:0] tdata;
  logic        tvalid;
  logic [3:0]  tstrb;   // One bit per byte lane
  logic        tready;
  logic        tlast;

  modport master
  (
    output tdata,
    output tvalid,
    output tstrb,
    output tlast,
    input  tready
  );

  modport slave
  (
    input  tdata,
    input  tvalid,
    input  tstrb,
    input  tlast,
    output tready
  );

  // Passive observer
  modport monitor
  (
    input tdata,
    input tvalid,
    input tstrb,
    input tlast,
    input tready
  );

endinterface

/* src/csi2_pkt_handler.sv */
`timescale 1ns/10ps

module csi2_pkt_handler
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          sop_i,
  axi4_stream_if.slave  pkt_i,
  axi4_stream_if.master pkt_o
);

  import csi2_data_types_pkg::*;

  typedef enum logic [1:0] {
    IDLE_S,
    RUN_S,
    IGNORE_CRC_S
  } state_t;

  state_t      state;
  state_t      next_state;
  csi2_hdr_t   hdr;
  logic        in_acc;
  logic        raw10_hdr;
  logic [15:0] pkt_size;
  logic [15:0] byte_cnt;
  logic [15:0] byte_cnt_comb;
  logic [3:0]  pl_strb;

  assign pkt_i.tready = pkt_o.tready;   // No buffering so ready goes straight up

  assign in_acc    = pkt_i.tvalid && pkt_i.tready;
  assign hdr       = pkt_i.tdata;
  assign raw10_hdr = in_acc && sop_i && (hdr.lng.data_type == RAW_10);

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Packet FSM
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      state <= IDLE_S;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE_S:
      begin
        if (raw10_hdr)
          next_state = RUN_S;
      end
      RUN_S:
      begin
        if (in_acc && (byte_cnt_comb >= pkt_size))
        begin
          // Both CRC bytes still to come or the second one alone
          if ((pkt_size[1:0] == 2'd0) || (pkt_size[1:0] == 2'd3))
            next_state = IGNORE_CRC_S;
          else
            next_state = IDLE_S;
        end
      end
      IGNORE_CRC_S:
      begin
        if (in_acc)
          next_state = IDLE_S;
      end
      default: next_state = IDLE_S;
    endcase
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      pkt_size <= '0;
    else if ((state == IDLE_S) && raw10_hdr)
      pkt_size <= hdr.lng.word_cnt;
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Byte counting
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    byte_cnt_comb = byte_cnt;
    if (state == RUN_S)
    begin
      if (in_acc)
        for (int i = 0; i < 4; i++)
          if (pkt_i.tstrb[i])
            byte_cnt_comb = byte_cnt_comb + 16'd1;
    end
    else
      byte_cnt_comb = '0;
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      byte_cnt <= '0;
    else
      byte_cnt <= byte_cnt_comb;
  end

  // Lanes past the word count carry CRC
  always_comb
  begin
    for (int i = 0; i < 4; i++)
      pl_strb[i] = pkt_i.tstrb[i] && ((byte_cnt + 16'(i)) < pkt_size);
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output stage
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i)
  begin
    if (in_acc)
    begin
      pkt_o.tdata <= pkt_i.tdata;
      pkt_o.tstrb <= pl_strb;
    end
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      pkt_o.tvalid <= 1'b0;
    else if (in_acc)
      pkt_o.tvalid <= (state == RUN_S) && (byte_cnt < pkt_size);
    else if (pkt_o.tready)
      pkt_o.tvalid <= 1'b0;
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      pkt_o.tlast <= 1'b0;
    else if (in_acc)
      pkt_o.tlast <= (state == RUN_S) && (byte_cnt_comb >= pkt_size) &&
                     (byte_cnt < pkt_size);   // Word that completes the count
    else if (pkt_o.tready)
      pkt_o.tlast <= 1'b0;
  end

endmodule

/* src/csi2_short_pkt_decoder.sv */
`timescale 1ns/10ps

module csi2_short_pkt_decoder
(
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           sop_i,
  axi4_stream_if.monitor pkt_i,
  output logic           fs_pulse_o,
  output logic           frame_end_o,
  output logic [15:0]    frame_num_o
);

  import csi2_data_types_pkg::*;

  csi2_hdr_t hdr;
  logic      hdr_acc;
  logic      is_fs;
  logic      is_fe;

  assign hdr     = pkt_i.tdata;
  assign hdr_acc = pkt_i.tvalid && pkt_i.tready && sop_i;

  assign is_fs = hdr_acc && (hdr.shrt.data_type == FRAME_START);
  assign is_fe = hdr_acc && (hdr.shrt.data_type == FRAME_END);

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame marks
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Single cycle strobe per accepted header
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      fs_pulse_o  <= 1'b0;
      frame_end_o <= 1'b0;
    end
    else
    begin
      fs_pulse_o  <= is_fs;
      frame_end_o <= is_fe;
    end
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      frame_num_o <= '0;
    else if (is_fs)
      frame_num_o <= hdr.shrt.data_field;   // Held until next FS
  end

endmodule

/* raw10_unpacker/csi2_raw10_unpacker.sv */
`timescale 1ns/10ps

module csi2_raw10_unpacker
(
  input  logic         clk_i,
  input  logic         rst_i,
  axi4_stream_if.slave pl_i,
  input  logic         fs_pulse_i,
  output logic [csi2_data_types_pkg::PX_W*csi2_data_types_pkg::PX_PER_GRP-1:0] px_o,
  output logic         px_valid_o,
  output logic         sof_o,
  output logic         eol_o
);

  import csi2_data_types_pkg::*;

  localparam logic [3:0] GRP_BYTES = 4'(PX_PER_GRP + 1);

  logic                         beat_acc;
  logic [2:0]                   buf_cnt;    // Bytes held over (0 to 4)
  logic [31:0]                  buf_q;
  logic [31:0]                  buf_m;
  logic [31:0]                  in_m;
  logic [2:0]                   in_cnt;
  logic [3:0]                   sum_cnt;
  logic [3:0]                   rem_cnt;
  logic [63:0]                  merged;
  logic                         grp_rdy;
  logic [PX_W*PX_PER_GRP-1:0]   grp_px;
  logic                         sof_pend;

  assign beat_acc = pl_i.tvalid && pl_i.tready;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Byte buffer
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    in_cnt = '0;
    for (int j = 0; j < 4; j++)
    begin
      buf_m[8*j +: 8] = (j < int'(buf_cnt)) ? buf_q[8*j +: 8] : 8'h00;
      in_m[8*j +: 8]  = pl_i.tstrb[j] ? pl_i.tdata[8*j +: 8] : 8'h00;
      if (pl_i.tstrb[j])
        in_cnt = in_cnt + 3'd1;
    end
  end

  // New bytes land right after the held ones
  assign merged  = {32'h0, buf_m} | ({32'h0, in_m} << {buf_cnt, 3'b000});
  assign sum_cnt = {1'b0, buf_cnt} + {1'b0, in_cnt};
  assign rem_cnt = sum_cnt - GRP_BYTES;
  assign grp_rdy = beat_acc && (sum_cnt >= GRP_BYTES);

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      buf_cnt <= '0;
    else if (beat_acc)
    begin
      if (pl_i.tlast)
        buf_cnt <= '0;   // Line end flushes leftovers
      else if (grp_rdy)
        buf_cnt <= rem_cnt[2:0];
      else
        buf_cnt <= sum_cnt[2:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (beat_acc)
    begin
      if (grp_rdy)
        buf_q <= {8'h00, merged[63:40]};
      else
        buf_q <= merged[31:0];
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pixel group
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // High byte per pixel with the low bits packed in the fifth byte
  always_comb
  begin
    for (int i = 0; i < PX_PER_GRP; i++)
      grp_px[PX_W*i +: PX_W] = {merged[8*i +: 8], merged[8*PX_PER_GRP + 2*i +: 2]};
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      sof_pend <= 1'b0;
    else if (fs_pulse_i)
      sof_pend <= 1'b1;
    else if (grp_rdy)
      sof_pend <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (grp_rdy)
      px_o <= grp_px;
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      px_valid_o <= 1'b0;
      sof_o      <= 1'b0;
      eol_o      <= 1'b0;
    end
    else if (pl_i.tready)   // Hold while the sink stalls
    begin
      px_valid_o <= grp_rdy;
      sof_o      <= grp_rdy && sof_pend;
      eol_o      <= grp_rdy && pl_i.tlast;
    end
  end

endmodule

/* src/csi2_rx_top.sv */
`timescale 1ns/10ps

module csi2_rx_top
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] word_i,
  input  logic [3:0]  strb_i,
  input  logic        valid_i,
  input  logic        sop_i,
  output logic        ready_o,
  output logic [csi2_data_types_pkg::PX_W*csi2_data_types_pkg::PX_PER_GRP-1:0] px_o,
  output logic        px_valid_o,
  output logic        sof_o,
  output logic        eol_o,
  output logic [15:0] frame_num_o,
  output logic        frame_end_o,
  input  logic        px_ready_i
);

  logic fs_pulse;

  axi4_stream_if rx_bus ();
  axi4_stream_if payload_bus ();

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input stream
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rx_bus.tdata  = word_i;
  assign rx_bus.tstrb  = strb_i;
  assign rx_bus.tvalid = valid_i;
  assign rx_bus.tlast  = 1'b0;          // Packet bounds come from sop_i
  assign ready_o       = rx_bus.tready;

  assign payload_bus.tready = px_ready_i;   // Pixel sink stalls the whole path

  csi2_pkt_handler u_pkt_handler
  (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .sop_i (sop_i),
    .pkt_i (rx_bus.slave),
    .pkt_o (payload_bus.master)
  );

  csi2_short_pkt_decoder u_short_pkt_decoder
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sop_i       (sop_i),
    .pkt_i       (rx_bus.monitor),
    .fs_pulse_o  (fs_pulse),
    .frame_end_o (frame_end_o),
    .frame_num_o (frame_num_o)
  );

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pixel output
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  csi2_raw10_unpacker u_raw10_unpacker
  (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .pl_i       (payload_bus.slave),
    .fs_pulse_i (fs_pulse),
    .px_o       (px_o),
    .px_valid_o (px_valid_o),
    .sof_o      (sof_o),
    .eol_o      (eol_o)
  );

endmodule

/* verif/csi2_rx_asserts.sv */
`timescale 1ns/10ps

module csi2_rx_asserts
(
  input logic clk_i,
  input logic rst_i,
  input logic [csi2_data_types_pkg::PX_W*csi2_data_types_pkg::PX_PER_GRP-1:0] px_i,
  input logic px_valid_i,
  input logic sof_i,
  input logic eol_i,
  input logic px_ready_i,
  input logic frame_end_i
);

  int fail_cnt = 0;

  // Marks only ride on a valid group
  a_marks_need_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (sof_i || eol_i) |-> px_valid_i)
    else
    begin
      $error("sof/eol raised without a valid pixel group");
      fail_cnt++;
    end

  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    (px_valid_i && !px_ready_i) |=>
      (px_valid_i && $stable(px_i) && $stable(sof_i) && $stable(eol_i)))
    else
    begin
      $error("pixel output changed while the sink stalled");
      fail_cnt++;
    end

  a_frame_end_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    frame_end_i |=> !frame_end_i)
    else
    begin
      $error("frame_end_o longer than one cycle");
      fail_cnt++;
    end

endmodule

bind csi2_rx_top csi2_rx_asserts u_asserts
(
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .px_i        (px_o),
  .px_valid_i  (px_valid_o),
  .sof_i       (sof_o),
  .eol_i       (eol_o),
  .px_ready_i  (px_ready_i),
  .frame_end_i (frame_end_o)
);

/* verif/tb_csi2_rx_model.svh */
`ifndef TB_CSI2_RX_MODEL_SVH
`define TB_CSI2_RX_MODEL_SVH

// Beats for the driver with one entry per presented word or idle cycle
logic [31:0] beat_data_q[$];
logic [3:0]  beat_strb_q[$];
logic        beat_sop_q[$];
logic        beat_vld_q[$];

// Expected pixel groups and their marks
logic [39:0] exp_px_q[$];
logic        exp_sof_q[$];
logic        exp_eol_q[$];
logic [15:0] exp_fnum_q[$];
int          exp_line_q[$];   // Groups per line
int          exp_fe_cnt;
logic        sof_due;
logic [15:0] cur_fnum;

function automatic int unsigned rnd(input int unsigned n);
  return $unsigned($random(seed)) % n;
endfunction

task automatic push_beat(input logic [31:0] data, input logic [3:0] strb, input logic sop);
  if (rnd(8) == 0)
  begin
    beat_data_q.push_back(32'h0);   // Idle cycle with valid low
    beat_strb_q.push_back(4'h0);
    beat_sop_q.push_back(1'b0);
    beat_vld_q.push_back(1'b0);
  end
  beat_data_q.push_back(data);
  beat_strb_q.push_back(strb);
  beat_sop_q.push_back(sop);
  beat_vld_q.push_back(1'b1);
endtask

task automatic make_short(input logic [5:0] dt, input logic [15:0] field);
  push_beat({8'h00, field, 2'b00, dt}, 4'hF, 1'b1);
  if (dt == FRAME_START)
  begin
    sof_due  = 1'b1;
    cur_fnum = field;
  end
  if (dt == FRAME_END)
    exp_fe_cnt++;
endtask

// Long packet with payload and two CRC bytes whose RAW10 groups go to the model
task automatic pack_long(input logic [5:0] dt, input int wc);
  logic [7:0]  pl[$];
  logic [31:0] w;
  logic [3:0]  s;
  logic [9:0]  hi;
  logic [9:0]  lo;
  logic [39:0] grp;
  push_beat({8'h00, 16'(wc), 2'b00, dt}, 4'hF, 1'b1);
  for (int i = 0; i < wc + 2; i++)
    pl.push_back(8'(rnd(256)));
  for (int i = 0; i < wc + 2; i += 4)
  begin
    w = 32'h0;
    s = 4'h0;
    for (int j = 0; j < 4; j++)
    begin
      if (i + j < wc + 2)
      begin
        w[8*j +: 8] = pl[i+j];
        s[j]        = 1'b1;
      end
    end
    push_beat(w, s, 1'b0);
  end
  if (dt == RAW_10)
  begin
    for (int g = 0; g < wc / 5; g++)
    begin
      for (int p = 0; p < 4; p++)
      begin
        hi = pl[5*g + p];
        lo = (pl[5*g + 4] >> (2 * p)) & 8'h03;
        grp[10*p +: 10] = hi * 4 + lo;
      end
      exp_px_q.push_back(grp);
      exp_sof_q.push_back(sof_due);
      exp_eol_q.push_back(g == wc / 5 - 1);
      exp_fnum_q.push_back(cur_fnum);
      sof_due = 1'b0;
    end
    exp_line_q.push_back(wc / 5);
  end
endtask

task automatic add_frame(input int lines, input logic junk);
  make_short(FRAME_START, 16'(rnd(65536)));
  for (int l = 0; l < lines; l++)
  begin
    if (junk && (rnd(3) == 0))
      pack_long(6'h2A + 6'(2 * rnd(2)), 1 + rnd(40));   // RAW8 or RAW12
    pack_long(RAW_10, 5 * (1 + rnd(24)));
  end
  make_short(FRAME_END, cur_fnum);
endtask

`endif

/* verif/tb_csi2_rx.sv */
`timescale 1ns/10ps

module tb_csi2_rx;

  import csi2_data_types_pkg::*;

  logic        clk_i;
  logic        rst_i;
  logic [31:0] word_i;
  logic [3:0]  strb_i;
  logic        valid_i;
  logic        sop_i;
  logic        ready_o;
  logic [39:0] px_o;
  logic        px_valid_o;
  logic        sof_o;
  logic        eol_o;
  logic [15:0] frame_num_o;
  logic        frame_end_o;
  logic        px_ready_i;

  integer      seed = 32'h991a;
  int          err_cnt;
  int          test_cnt;
  int          grp_cnt;
  int          line_grps;
  int          fe_seen;
  int          ready_pct;   // Chance in percent that the sink is ready
  longint      cycle_cnt;
  longint      cycle_limit;

  `include "tb_csi2_rx_model.svh"

  csi2_rx_top dut_i
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .word_i      (word_i),
    .strb_i      (strb_i),
    .valid_i     (valid_i),
    .sop_i       (sop_i),
    .ready_o     (ready_o),
    .px_o        (px_o),
    .px_valid_o  (px_valid_o),
    .sof_o       (sof_o),
    .eol_o       (eol_o),
    .frame_num_o (frame_num_o),
    .frame_end_o (frame_end_o),
    .px_ready_i  (px_ready_i)
  );

  always #20 clk_i = ~clk_i;

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
    begin
      $display("Timeout: no end of run after %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output monitor sampled mid-cycle
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      check_val(ready_o, px_ready_i, "ready_o");
      if (frame_end_o)
        fe_seen++;
      if (px_valid_o && px_ready_i)   // Taken at the next rising edge
      begin
        if (exp_px_q.size() == 0)
        begin
          $display("Pixel group %0h arrived at %0d ns with none expected", px_o, $time);
          err_cnt++;
        end
        else
        begin
          check_val(px_o, exp_px_q.pop_front(), "pixel group");
          check_val(sof_o, exp_sof_q.pop_front(), "sof_o");
          check_val(eol_o, exp_eol_q.pop_front(), "eol_o");
          check_val(frame_num_o, exp_fnum_q.pop_front(), "frame_num_o");
          grp_cnt++;
          line_grps++;
          if (eol_o)
          begin
            check_val(line_grps, exp_line_q.pop_front(), "groups per line");
            line_grps = 0;
          end
        end
      end
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic drive_beats();
    while (beat_data_q.size() > 0)
    begin
      word_i  = beat_data_q.pop_front();
      strb_i  = beat_strb_q.pop_front();
      sop_i   = beat_sop_q.pop_front();
      valid_i = beat_vld_q.pop_front();
      do
      begin
        px_ready_i = (rnd(100) < ready_pct);
        @(posedge clk_i);
        #2;
      end
      while (valid_i && !ready_o);   // Hold the word until it is taken
    end
    valid_i = 1'b0;
    sop_i   = 1'b0;
  endtask

  task automatic drain();
    while (exp_px_q.size() > 0)
    begin
      px_ready_i = (rnd(100) < ready_pct);
      @(posedge clk_i);
      #2;
    end
    px_ready_i = 1'b1;
    repeat (8) @(posedge clk_i);   // Room for a stray extra group
    #2;
  endtask

  task automatic run_test(input string name, input int frames, input int pct, input logic junk);
    int errs_before;
    int grps_before;
    errs_before = err_cnt;
    grps_before = grp_cnt;
    ready_pct   = pct;
    for (int f = 0; f < frames; f++)
      add_frame(1 + rnd(4), junk);
    cycle_limit += 4 * beat_data_q.size();
    drive_beats();
    drain();
    check_val(fe_seen, exp_fe_cnt, "frame end pulses");
    test_cnt++;
    $display("%s: %0d groups, %0d errors", name, grp_cnt - grps_before, err_cnt - errs_before);
  endtask

  initial
  begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    word_i      = 32'h0;
    strb_i      = 4'h0;
    valid_i     = 1'b0;
    sop_i       = 1'b0;
    px_ready_i  = 1'b1;
    err_cnt     = 0;
    test_cnt    = 0;
    grp_cnt     = 0;
    line_grps   = 0;
    fe_seen     = 0;
    ready_pct   = 100;
    cycle_cnt   = 0;
    cycle_limit = 2000;
    exp_fe_cnt  = 0;
    sof_due     = 1'b0;
    cur_fnum    = 16'h0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    check_val(px_valid_o, 1'b0, "px_valid_o after reset");
    check_val(sof_o, 1'b0, "sof_o after reset");
    check_val(eol_o, 1'b0, "eol_o after reset");
    check_val(frame_end_o, 1'b0, "frame_end_o after reset");
    check_val(frame_num_o, 16'h0, "frame_num_o after reset");
    test_cnt++;
    $display("reset_state: %0d errors", err_cnt);
    run_test("clean_frames", 3, 100, 1'b0);
    run_test("filtered_packets", 3, 100, 1'b1);
    run_test("backpressure", 4, 60, 1'b1);
    err_cnt += dut_i.u_asserts.fail_cnt;
    $display("%0d tests, %0d groups, %0d errors", test_cnt, grp_cnt, err_cnt);
    if (err_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* files.f */
+incdir+verif
common/csi2_data_types_pkg.sv
common/axi4_stream_if.sv
src/csi2_pkt_handler.sv
src/csi2_short_pkt_decoder.sv
raw10_unpacker/csi2_raw10_unpacker.sv
src/csi2_rx_top.sv
verif/csi2_rx_asserts.sv
verif/tb_csi2_rx.sv
